// ==== alu.sv ====
`timescale 1ns/1ns

module alu (
    input  core_ctrl_pkg::alu_op_t i_op,
    input  rv_isa_pkg::word_t      i_a,
    input  rv_isa_pkg::word_t      i_b,
    output rv_isa_pkg::word_t      o_result,
    output logic                   o_zero,
    output logic                   o_last_bit
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLT:    o_result = {31'b0, $signed(i_a) < $signed(i_b)};
            ALU_SLTU:   o_result = {31'b0, i_a < i_b};
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SRL:    o_result = i_a >> shamt;
            ALU_SRA:    o_result = word_t'($signed(i_a) >>> shamt);
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

    // Flags feed branch resolution
    assign o_zero     = (o_result == '0);
    assign o_last_bit = o_result[0];

endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ns

module control_unit (
    input  rv_isa_pkg::instr_u   i_instr,
    input  logic                 i_stall,
    input  logic                 i_in_reset,
    input  logic                 i_alu_zero,
    input  logic                 i_alu_last_bit,
    output core_ctrl_pkg::ctrl_t o_ctrl,
    output logic [4:0]           o_rs1,
    output logic [4:0]           o_rs2,
    output logic [4:0]           o_rd
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    ctrl_t      ctrl_dec;
    logic [2:0] funct3;
    logic       funct7_alt;
    logic       is_branch;
    logic       taken;

    // Shared funct3 mapping for OP and OP-IMM
    function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic sub,
                                               input logic sra);
        alu_op_t op;
        case (f3)
            3'b000:  op = sub ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = sra ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign funct3     = i_instr.r.funct3;
    assign funct7_alt = i_instr.r.funct7[5];
    assign o_rs1      = i_instr.r.rs1;
    assign o_rs2      = i_instr.r.rs2;
    assign o_rd       = i_instr.r.rd;

    always_comb begin
        ctrl_dec            = '0;
        ctrl_dec.alu_op     = ALU_ADD;
        ctrl_dec.imm_src    = IMM_I;
        ctrl_dec.wb_src     = WB_ALU;
        ctrl_dec.pc_src     = PC_SRC_PLUS4;
        ctrl_dec.target_src = TGT_PC_IMM;
        case (i_instr.r.opcode)
            OPC_OP: begin
                ctrl_dec.alu_op    = alu_from_funct(funct3, funct7_alt, funct7_alt);
                ctrl_dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                // No SUB form for immediates
                ctrl_dec.alu_op      = alu_from_funct(funct3, 1'b0, funct7_alt);
                ctrl_dec.alu_src_imm = 1'b1;
                ctrl_dec.reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                ctrl_dec.alu_src_imm = 1'b1;
                ctrl_dec.mem_read    = 1'b1;
                ctrl_dec.reg_write   = 1'b1;
                ctrl_dec.wb_src      = WB_MEM;
            end
            OPC_STORE: begin
                ctrl_dec.imm_src     = IMM_S;
                ctrl_dec.alu_src_imm = 1'b1;
                ctrl_dec.mem_write   = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl_dec.imm_src = IMM_B;
                case (funct3[2:1])
                    2'b10:   ctrl_dec.alu_op = ALU_SLT;
                    2'b11:   ctrl_dec.alu_op = ALU_SLTU;
                    default: ctrl_dec.alu_op = ALU_SUB;
                endcase
            end
            OPC_JAL: begin
                ctrl_dec.imm_src   = IMM_J;
                ctrl_dec.reg_write = 1'b1;
                ctrl_dec.wb_src    = WB_PC_PLUS4;
                ctrl_dec.pc_src    = PC_SRC_TARGET;
            end
            OPC_JALR: begin
                ctrl_dec.reg_write  = 1'b1;
                ctrl_dec.wb_src     = WB_PC_PLUS4;
                ctrl_dec.pc_src     = PC_SRC_TARGET;
                ctrl_dec.target_src = TGT_RS1_IMM;
            end
            OPC_LUI: begin
                ctrl_dec.imm_src     = IMM_U;
                ctrl_dec.alu_op      = ALU_PASS_B;
                ctrl_dec.alu_src_imm = 1'b1;
                ctrl_dec.reg_write   = 1'b1;
                ctrl_dec.target_src  = TGT_IMM;
            end
            OPC_AUIPC: begin
                ctrl_dec.imm_src   = IMM_U;
                ctrl_dec.reg_write = 1'b1;
                ctrl_dec.wb_src    = WB_TARGET;
            end
            default: begin
                // Unsupported opcodes fall through as a NOP
                ctrl_dec.reg_write = 1'b0;
            end
        endcase
    end

    // Equal or less-than test inverted by funct3[0] for BNE/BGE/BGEU
    assign is_branch = (i_instr.r.opcode == OPC_BRANCH);
    assign taken     = (funct3[2] ? i_alu_last_bit : i_alu_zero) ^ funct3[0];

    always_comb begin
        o_ctrl = ctrl_dec;
        if (is_branch && taken) begin
            o_ctrl.pc_src = PC_SRC_TARGET;
        end
        // Reset and stall both freeze architectural state
        if (i_in_reset || i_stall) begin
            o_ctrl.reg_write = 1'b0;
            o_ctrl.mem_write = 1'b0;
            o_ctrl.pc_src    = PC_SRC_HOLD;
        end
    end

endmodule

// ==== core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU      = 2'd0,
        WB_MEM      = 2'd1,
        WB_PC_PLUS4 = 2'd2,
        WB_TARGET   = 2'd3
    } wb_src_t;

    typedef enum logic [1:0] {
        PC_SRC_PLUS4  = 2'd0,
        PC_SRC_HOLD   = 2'd1,
        PC_SRC_TARGET = 2'd2
    } pc_src_t;

    // Operand choice for the second adder
    typedef enum logic [1:0] {
        TGT_PC_IMM  = 2'd0,
        TGT_IMM     = 2'd1,
        TGT_RS1_IMM = 2'd2
    } target_src_t;

    typedef struct packed {
        alu_op_t              alu_op;
        rv_isa_pkg::imm_src_t imm_src;
        logic                 alu_src_imm;
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
        wb_src_t              wb_src;
        pc_src_t              pc_src;
        target_src_t          target_src;
    } ctrl_t;

    typedef struct packed {
        rv_isa_pkg::addr_t addr;
        rv_isa_pkg::word_t wdata;
        logic [3:0]        be;
        logic              we;
    } dmem_req_t;

    typedef struct packed {
        logic              valid;
        logic [4:0]        rd;
        rv_isa_pkg::word_t data;
    } retire_t;

endpackage

// ==== data_ram.sv ====
`timescale 1ns/1ns

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                     clk,
    input  core_ctrl_pkg::dmem_req_t i_req,
    output rv_isa_pkg::word_t        o_rdata
);

    import rv_isa_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);

    word_t         mem [RAM_WORDS];
    logic [AW-1:0] idx;

    // Word index with the byte offset dropped
    assign idx     = i_req.addr[AW+1:2];
    assign o_rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (i_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_req.be[b]) begin
                    mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== imm_extend.sv ====
`timescale 1ns/1ns

module imm_extend (
    input  rv_isa_pkg::instr_u   i_instr,
    input  rv_isa_pkg::imm_src_t i_imm_src,
    output rv_isa_pkg::word_t    o_imm
);

    import rv_isa_pkg::*;

    always_comb begin
        case (i_imm_src)
            IMM_I: o_imm = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
            IMM_S: o_imm = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
            IMM_B: begin
                o_imm = {{20{i_instr.b.imm12}}, i_instr.b.imm11, i_instr.b.imm10_5,
                         i_instr.b.imm4_1, 1'b0};
            end
            IMM_U: o_imm = {i_instr.u.imm31_12, 12'b0};
            IMM_J: begin
                o_imm = {{12{i_instr.j.imm20}}, i_instr.j.imm19_12, i_instr.j.imm11,
                         i_instr.j.imm10_1, 1'b0};
            end
            default: o_imm = '0;
        endcase
    end

endmodule

// ==== load_store_unit.sv ====
`timescale 1ns/1ns

module load_store_unit (
    input  core_ctrl_pkg::ctrl_t     i_ctrl,
    input  logic [2:0]               i_funct3,
    input  rv_isa_pkg::word_t        i_alu_result,
    input  rv_isa_pkg::word_t        i_rs2,
    input  rv_isa_pkg::addr_t        i_pc_plus4,
    input  rv_isa_pkg::addr_t        i_target,
    input  rv_isa_pkg::word_t        i_ram_rdata,
    output core_ctrl_pkg::dmem_req_t o_req,
    output rv_isa_pkg::word_t        o_wb_data
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [1:0] offset;
    word_t      shifted;
    word_t      load_data;

    assign offset = i_alu_result[1:0];

    // Store lanes follow the low address bits
    always_comb begin
        o_req.addr = i_alu_result;
        o_req.we   = i_ctrl.mem_write;
        case (i_funct3[1:0])
            2'b00: begin
                o_req.be    = 4'b0001 << offset;
                o_req.wdata = {4{i_rs2[7:0]}};
            end
            2'b01: begin
                o_req.be    = 4'b0011 << {offset[1], 1'b0};
                o_req.wdata = {2{i_rs2[15:0]}};
            end
            default: begin
                o_req.be    = 4'b1111;
                o_req.wdata = i_rs2;
            end
        endcase
    end

    assign shifted = i_ram_rdata >> {offset, 3'b000};

    always_comb begin
        case (i_funct3)
            3'b000:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  load_data = {24'b0, shifted[7:0]};
            3'b101:  load_data = {16'b0, shifted[15:0]};
            default: load_data = i_ram_rdata;
        endcase
        if (!i_ctrl.mem_read) begin
            load_data = '0;
        end
    end

    // Write-back select
    always_comb begin
        case (i_ctrl.wb_src)
            WB_MEM:      o_wb_data = load_data;
            WB_PC_PLUS4: o_wb_data = i_pc_plus4;
            WB_TARGET:   o_wb_data = i_target;
            default:     o_wb_data = i_alu_result;
        endcase
    end

endmodule

// ==== pc_unit.sv ====
`timescale 1ns/1ns

module pc_unit #(
    parameter rv_isa_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_ctrl_pkg::pc_src_t i_pc_src,
    input  rv_isa_pkg::addr_t      i_target,
    output rv_isa_pkg::addr_t      o_pc,
    output rv_isa_pkg::addr_t      o_pc_plus4
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    addr_t pc_q;
    addr_t pc_next;

    assign o_pc       = pc_q;
    assign o_pc_plus4 = pc_q + 32'd4;

    always_comb begin
        case (i_pc_src)
            PC_SRC_HOLD:   pc_next = pc_q;
            PC_SRC_TARGET: pc_next = i_target;
            default:       pc_next = o_pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ns

module regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [4:0]        i_rs1,
    input  logic [4:0]        i_rs2,
    input  logic [4:0]        i_rd,
    input  logic              i_we,
    input  rv_isa_pkg::word_t i_wdata,
    output rv_isa_pkg::word_t o_rdata1,
    output rv_isa_pkg::word_t o_rdata2
);

    import rv_isa_pkg::*;

    word_t regs [32];

    // x0 always reads as zero
    assign o_rdata1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != 5'd0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ns

module rv_core #(
    parameter rv_isa_pkg::addr_t RESET_PC  = 32'h0000_0000,
    parameter int                RAM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_isa_pkg::instr_u     i_instr,
    input  logic                   i_stall,
    output rv_isa_pkg::addr_t      o_pc,
    output core_ctrl_pkg::retire_t o_retire
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    addr_t      pc;
    addr_t      pc_plus4;
    addr_t      target;
    ctrl_t      ctrl;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    word_t      imm;
    word_t      rdata1;
    word_t      rdata2;
    word_t      alu_b;
    word_t      alu_result;
    logic       alu_zero;
    logic       alu_last_bit;
    dmem_req_t  dmem_req;
    word_t      ram_rdata;
    word_t      wb_data;

    pc_unit #(
        .RESET_PC(RESET_PC)
    ) u_pc_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_pc_src  (ctrl.pc_src),
        .i_target  (target),
        .o_pc      (pc),
        .o_pc_plus4(pc_plus4)
    );

    control_unit u_control_unit (
        .i_instr       (i_instr),
        .i_stall       (i_stall),
        .i_in_reset    (~rst_n),
        .i_alu_zero    (alu_zero),
        .i_alu_last_bit(alu_last_bit),
        .o_ctrl        (ctrl),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .o_rd          (rd)
    );

    imm_extend u_imm_extend (
        .i_instr  (i_instr),
        .i_imm_src(ctrl.imm_src),
        .o_imm    (imm)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_rs1   (rs1),
        .i_rs2   (rs2),
        .i_rd    (rd),
        .i_we    (ctrl.reg_write),
        .i_wdata (wb_data),
        .o_rdata1(rdata1),
        .o_rdata2(rdata2)
    );

    assign alu_b = ctrl.alu_src_imm ? imm : rdata2;

    alu u_alu (
        .i_op      (ctrl.alu_op),
        .i_a       (rdata1),
        .i_b       (alu_b),
        .o_result  (alu_result),
        .o_zero    (alu_zero),
        .o_last_bit(alu_last_bit)
    );

    // Second adder for branches, jumps and AUIPC
    always_comb begin
        case (ctrl.target_src)
            TGT_IMM:     target = imm;
            TGT_RS1_IMM: target = (rdata1 + imm) & ~32'd1;
            default:     target = pc + imm;
        endcase
    end

    load_store_unit u_load_store_unit (
        .i_ctrl      (ctrl),
        .i_funct3    (i_instr.r.funct3),
        .i_alu_result(alu_result),
        .i_rs2       (rdata2),
        .i_pc_plus4  (pc_plus4),
        .i_target    (target),
        .i_ram_rdata (ram_rdata),
        .o_req       (dmem_req),
        .o_wb_data   (wb_data)
    );

    data_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) u_data_ram (
        .clk    (clk),
        .i_req  (dmem_req),
        .o_rdata(ram_rdata)
    );

    assign o_pc           = pc;
    assign o_retire.valid = ctrl.reg_write;
    assign o_retire.rd    = rd;
    assign o_retire.data  = wb_data;

endmodule

// ==== rv_core_assertions.sv ====
`timescale 1ns/1ns

module rv_core_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   i_stall,
    input core_ctrl_pkg::ctrl_t   i_ctrl,
    input rv_isa_pkg::addr_t      i_pc,
    input core_ctrl_pkg::retire_t i_retire
);

    // Running count of assertion failures
    int unsigned fail_count = 0;

    // Stalled cycles must not touch registers or memory
    a_stall_no_write: assert property (@(posedge clk)
        i_stall |-> (!i_ctrl.mem_write && !i_ctrl.reg_write))
        else begin
            $error("write enable active while i_stall is high");
            fail_count++;
        end

    a_stall_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_stall |=> (i_pc == $past(i_pc)))
        else begin
            $error("PC changed across a stalled edge");
            fail_count++;
        end

    // Nothing retires while reset is applied
    a_reset_no_retire: assert property (@(posedge clk)
        !rst_n |-> !i_retire.valid)
        else begin
            $error("retire valid seen during reset");
            fail_count++;
        end

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_stall (i_stall),
    .i_ctrl  (ctrl),
    .i_pc    (pc),
    .i_retire(o_retire)
);

// ==== rv_core_vectors.txt ====
// stall instr expected_pc retire_valid retire_rd retire_data (hex, one cycle per line)
// Reset PC is 0x100, store and branch lines expect no retire
0 00500093 00000100 1 01 00000005
0 FFD00113 00000104 1 02 FFFFFFFD
0 123451B7 00000108 1 03 12345000
0 00001217 0000010C 1 04 0000110C
// register-register ALU
0 002082B3 00000110 1 05 00000002
0 40208333 00000114 1 06 00000008
0 001123B3 00000118 1 07 00000001
0 00113433 0000011C 1 08 00000000
0 001094B3 00000120 1 09 000000A0
0 40115533 00000124 1 0A FFFFFFFF
0 001155B3 00000128 1 0B 07FFFFFF
0 0030C633 0000012C 1 0C 12345005
0 00708013 00000130 1 00 0000000C
0 001006B3 00000134 1 0D 00000005
// stores then loads at 0x40
0 04000713 00000138 1 0E 00000040
0 00372023 0000013C 0 00 00000000
0 001700A3 00000140 0 00 00000000
0 00271123 00000144 0 00 00000000
0 00072783 00000148 1 0F FFFD0500
0 00370803 0000014C 1 10 FFFFFFFF
0 00374883 00000150 1 11 000000FF
0 00271903 00000154 1 12 FFFFFFFD
0 00275983 00000158 1 13 0000FFFD
0 00170A03 0000015C 1 14 00000005
// branches and jumps
0 00D08463 00000160 0 00 00000000
0 00D09463 00000168 0 00 00000000
0 00114663 0000016C 0 00 00000000
0 00116463 00000178 0 00 00000000
0 FE20DCE3 0000017C 0 00 00000000
0 00117863 00000174 0 00 00000000
0 01000AEF 00000184 1 15 00000188
0 1A000B13 00000194 1 16 000001A0
0 004B0BE7 00000198 1 17 0000019C
// stalled store and stalled ADDI leave no trace
1 00072023 000001A4 0 00 00000000
1 00900093 000001A4 0 00 00000000
0 00072C03 000001A4 1 18 FFFD0500
0 00178CB3 000001A8 1 19 FFFD0505
0 00F1FD33 000001AC 1 1A 12340000
0 00C0EDB3 000001B0 1 1B 12345005

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // RV32I major opcodes used by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_src_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    // Branch offset bits are scattered across the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_fmt_t;

    // One fetched word seen through every encoding format
    typedef union packed {
        word_t  raw;
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

// ==== tb.f ====
rv_isa_pkg.sv
core_ctrl_pkg.sv
pc_unit.sv
control_unit.sv
imm_extend.sv
regfile.sv
alu.sv
load_store_unit.sv
data_ram.sv
rv_core.sv
rv_core_assertions.sv
tb_rv_core.sv

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 3;
    localparam int    MAX_VEC      = 64;
    localparam int    FIELDS       = 6;
    localparam int    MAX_EXTRA    = 8;
    localparam addr_t RESET_PC     = 32'h0000_0100;
    localparam word_t NOP          = 32'h0000_0013;

    // One line of the vector file
    typedef struct packed {
        logic    stall;
        instr_u  instr;
        addr_t   pc;
        retire_t retire;
    } vector_t;

    logic    clk;
    logic    rst_n;
    logic    stall;
    instr_u  instr;
    addr_t   pc;
    retire_t retire;

    word_t  vec_words [FIELDS*MAX_VEC];
    int     n_vec;
    int     pc_errors;
    int     retire_errors;
    int     load_errors;
    int     extra_stalls;
    integer seed;

    rv_core #(
        .RESET_PC (RESET_PC),
        .RAM_WORDS(256)
    ) dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_instr (instr),
        .i_stall (stall),
        .o_pc    (pc),
        .o_retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic vector_t unpack_vector(input int idx);
        vector_t v;
        v.stall        = vec_words[FIELDS*idx][0];
        v.instr.raw    = vec_words[FIELDS*idx+1];
        v.pc           = vec_words[FIELDS*idx+2];
        v.retire.valid = vec_words[FIELDS*idx+3][0];
        v.retire.rd    = vec_words[FIELDS*idx+4][4:0];
        v.retire.data  = vec_words[FIELDS*idx+5];
        return v;
    endfunction

    task automatic check_pc(input addr_t expected, input addr_t actual, input int step);
        if (actual !== expected) begin
            pc_errors++;
            $display("FAIL at %0t ns: vector %0d o_pc expected %h, got %h",
                     $time, step, expected, actual);
        end
    endtask

    task automatic check_retire(input retire_t expected, input retire_t actual,
                                input int step);
        logic  bad;
        string got;
        // Only valid is defined when nothing retires
        if (expected.valid) begin
            bad = (actual !== expected);
        end else begin
            bad = (actual.valid !== 1'b0);
        end
        if (bad) begin
            retire_errors++;
            got = $sformatf("got v=%0b rd=%0d data=%h", actual.valid, actual.rd, actual.data);
            $display("FAIL at %0t ns: vector %0d retire expected v=%0b rd=%0d data=%h, %s",
                     $time, step, expected.valid, expected.rd, expected.data, got);
        end
    endtask

    // Called right after a falling edge and returns at the next one
    task automatic apply_vector(input vector_t v, input int step);
        stall = v.stall;
        instr = v.instr;
        #(CLK_PERIOD/2 - 1);
        check_pc(v.pc, pc, step);
        check_retire(v.retire, retire, step);
        @(negedge clk);
    endtask

    initial begin
        vector_t v;
        vector_t held;
        int      total;
        string   counts;
        pc_errors     = 0;
        retire_errors = 0;
        load_errors   = 0;
        extra_stalls  = 0;
        seed          = 44;
        rst_n         = 1'b0;
        stall         = 1'b0;
        instr.raw     = NOP;

        for (int w = 0; w < FIELDS*MAX_VEC; w++) begin
            vec_words[w] = '0;
        end
        $readmemh("rv_core_vectors.txt", vec_words);
        n_vec = 0;
        // An all-zero instruction word is illegal and marks the unused slots
        while (n_vec < MAX_VEC && !$isunknown(vec_words[FIELDS*n_vec+1]) &&
               vec_words[FIELDS*n_vec+1] != '0) begin
            n_vec++;
        end
        if (n_vec == 0) begin
            load_errors++;
            $display("No vectors could be read from rv_core_vectors.txt");
        end

        for (int r = 0; r < RESET_CYCLES; r++) begin
            @(posedge clk);
            #1;
            check_pc(RESET_PC, pc, -1);
            check_retire('0, retire, -1);
        end

        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < n_vec; k++) begin
            v = unpack_vector(k);
            // Occasionally hold the same instruction under stall first
            if (!v.stall && extra_stalls < MAX_EXTRA && ($random(seed) & 3) == 0) begin
                held        = v;
                held.stall  = 1'b1;
                held.retire = '0;
                extra_stalls++;
                apply_vector(held, k);
            end
            apply_vector(v, k);
        end

        total = pc_errors + retire_errors + load_errors + dut.u_assertions.fail_count;
        counts = $sformatf("Errors: pc=%0d retire=%0d assertions=%0d load=%0d",
                           pc_errors, retire_errors, dut.u_assertions.fail_count,
                           load_errors);
        $display("%s over %0d vectors, %0d extra stalls", counts, n_vec, extra_stalls);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the vector count read at time zero
    initial begin
        int limit;
        #1;
        limit = (RESET_CYCLES + n_vec + MAX_EXTRA + 2) * CLK_PERIOD + 100;
        #(limit);
        $display("Timeout: the vector run did not finish within %0d ns", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule
